// ==== source/vmem_pkg.sv ====
`default_nettype none

package vmem_pkg;

	localparam int VMEM_DATA_W      = 16;
	localparam int VMEM_BANK_ADDR_W = 14;
	localparam int VMEM_N_BANKS     = 4;

	typedef struct packed {
		logic [1:0]                  bank;   // top bits pick the bank
		logic [VMEM_BANK_ADDR_W-1:0] offset;
	} vmem_bank_addr_t;

	typedef union packed {
		logic [VMEM_DATA_W-1:0] word;
		vmem_bank_addr_t        split;
	} vmem_addr_u;

	// order is the priority order, sprite first
	typedef enum logic [1:0] {
		CL_SPRITE = 2'd0,
		CL_BG     = 2'd1,
		CL_AUDIO  = 2'd2,
		CL_CPU    = 2'd3
	} client_e;

	typedef logic [3:0] grant_t;   // one-hot by client_e, zero when idle

endpackage

`default_nettype wire

// ==== source/bank_port_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface bank_port_if
	import vmem_pkg::*;
#(
	parameter int DATA_W      = VMEM_DATA_W,
	parameter int BANK_ADDR_W = VMEM_BANK_ADDR_W
);

	logic [BANK_ADDR_W-1:0] addr;
	logic [DATA_W-1:0]      wdata;
	logic                   wr;
	logic [DATA_W-1:0]      rdata;   // registered read of last addr

	modport arb (
		output addr,
		output wdata,
		output wr,
		input  rdata
	);

	modport ram (
		input  addr,
		input  wdata,
		input  wr,
		output rdata
	);

endinterface

`default_nettype wire

// ==== source/bank_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module bank_arbiter
	import vmem_pkg::*;
#(
	parameter int unsigned BANK_ID = 0
) (
	input  wire                   CLK,
	input  wire                   RSTb,

	input  wire [15:0]            sp_addr,
	input  wire                   sp_valid,
	input  wire [15:0]            bg_addr,
	input  wire                   bg_valid,
	input  wire [15:0]            au_addr,
	input  wire                   au_valid,
	input  wire [15:0]            cpu_addr,
	input  wire                   cpu_valid,
	input  wire [VMEM_DATA_W-1:0] cpu_wdata,
	input  wire                   cpu_wr,

	bank_port_if.arb              mem,
	output grant_t                grant
);

	vmem_addr_u req_addr [4];   // indexed by client_e
	grant_t     req_valid;
	grant_t     hit;             // valid and aimed at this bank
	grant_t     grant_r;
	grant_t     grant_next;
	client_e    pick;
	client_e    held;
	client_e    sel;
	logic       active;

	always_comb begin
		req_addr[CL_SPRITE].word = sp_addr;
		req_addr[CL_BG].word     = bg_addr;
		req_addr[CL_AUDIO].word  = au_addr;
		req_addr[CL_CPU].word    = cpu_addr;
	end

	assign req_valid = {cpu_valid, au_valid, bg_valid, sp_valid};

	always_comb begin
		hit = '0;
		for (int i = 0; i < 4; i++) begin
			hit[i] = req_valid[i] && (req_addr[i].split.bank == 2'(BANK_ID));
		end
	end

	// fixed priority, lowest index wins
	always_comb begin
		pick = CL_CPU;
		for (int i = 3; i >= 0; i--) begin
			if (hit[i])
				pick = client_e'(i);
		end
	end

	// encode current holder
	always_comb begin
		held = CL_CPU;
		for (int i = 3; i >= 0; i--) begin
			if (grant_r[i])
				held = client_e'(i);
		end
	end

	always_comb begin
		grant_next = grant_r;
		sel        = held;
		active     = 1'b0;
		if (grant_r == '0) begin
			if (hit != '0) begin
				sel              = pick;
				active           = 1'b1;
				grant_next[pick] = 1'b1;
			end
		end else begin
			active = 1'b1;
			if (!req_valid[held])
				grant_next = '0;   // released, idle next cycle
		end
	end

	always_ff @(posedge CLK) begin
		if (!RSTb)
			grant_r <= '0;
		else
			grant_r <= grant_next;
	end

	assign grant = grant_r;

	// holder's offset goes straight to the ram, also while granted
	always_comb begin
		mem.addr  = '0;
		mem.wdata = '0;
		mem.wr    = 1'b0;
		if (active) begin
			mem.addr = req_addr[sel].split.offset;
			if (sel == CL_CPU) begin
				mem.wdata = cpu_wdata;
				mem.wr    = cpu_wr && cpu_valid;   // no write once valid drops
			end
		end
	end

	a_grant_onehot: assert property (@(posedge CLK) disable iff (!RSTb)
		$onehot0(grant_r))
		else $error("bank %0d grant not one-hot", BANK_ID);

	// a write always belongs to a cpu grant that is live next cycle
	a_wr_cpu_only: assert property (@(posedge CLK) disable iff (!RSTb)
		mem.wr |=> grant_r[CL_CPU])
		else $error("bank %0d write without cpu grant", BANK_ID);

endmodule

`default_nettype wire

// ==== source/bank_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

module bank_ram #(
	parameter int DATA_W      = 16,
	parameter int BANK_ADDR_W = 14
) (
	input wire       CLK,
	bank_port_if.ram mem
);

	localparam int DEPTH = 2 ** BANK_ADDR_W;

	logic [DATA_W-1:0] store [DEPTH];
	logic [DATA_W-1:0] rd_q;

	// read-first, rd_q gets the old word on a write
	always_ff @(posedge CLK) begin
		if (mem.wr)
			store[mem.addr] <= mem.wdata;
		rd_q <= store[mem.addr];
	end

	assign mem.rdata = rd_q;

endmodule

`default_nettype wire

// ==== source/read_return.sv ====
`timescale 1ns/1ps
`default_nettype none

module read_return
	import vmem_pkg::*;
(
	input  wire                    CLK,
	input  wire                    RSTb,

	input  wire grant_t            grants [VMEM_N_BANKS],
	input  wire [VMEM_DATA_W-1:0]  rdata  [VMEM_N_BANKS],

	output logic [VMEM_DATA_W-1:0] sp_data,
	output logic [VMEM_DATA_W-1:0] bg_data,
	output logic [VMEM_DATA_W-1:0] au_data,
	output logic [VMEM_DATA_W-1:0] cpu_data,
	output logic                   sp_ready,
	output logic                   bg_ready,
	output logic                   au_ready,
	output logic                   cpu_ready
);

	logic [VMEM_DATA_W-1:0] cl_data [4];   // indexed by client_e
	grant_t                 cl_ready;

	// and-or merge, a client sits in at most one bank
	always_comb begin
		cl_ready = '0;
		for (int c = 0; c < 4; c++) begin
			cl_data[c] = '0;
		end
		for (int b = 0; b < VMEM_N_BANKS; b++) begin
			for (int c = 0; c < 4; c++) begin
				if (grants[b][c]) begin
					cl_ready[c] = 1'b1;
					cl_data[c]  = cl_data[c] | rdata[b];
				end
			end
		end
	end

	assign sp_data   = cl_data[CL_SPRITE];
	assign bg_data   = cl_data[CL_BG];
	assign au_data   = cl_data[CL_AUDIO];
	assign cpu_data  = cl_data[CL_CPU];
	assign sp_ready  = cl_ready[CL_SPRITE];
	assign bg_ready  = cl_ready[CL_BG];
	assign au_ready  = cl_ready[CL_AUDIO];
	assign cpu_ready = cl_ready[CL_CPU];

	for (genvar c = 0; c < 4; c++) begin : g_chk
		logic [VMEM_N_BANKS-1:0] banks_of;

		always_comb begin
			for (int b = 0; b < VMEM_N_BANKS; b++) begin
				banks_of[b] = grants[b][c];
			end
		end

		// clients must not hop banks while they hold a grant
		a_one_bank: assert property (@(posedge CLK) disable iff (!RSTb)
			$onehot0(banks_of))
			else $error("client %0d granted by two banks", c);

		a_quiet_data: assert property (@(posedge CLK) disable iff (!RSTb)
			!cl_ready[c] |-> cl_data[c] == '0)
			else $error("client %0d data not zero without ready", c);
	end

endmodule

`default_nettype wire

// ==== source/vmem_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module vmem_top
	import vmem_pkg::*;
#(
	parameter int DATA_W      = VMEM_DATA_W,
	parameter int BANK_ADDR_W = VMEM_BANK_ADDR_W
) (
	input  wire               CLK,
	input  wire               RSTb,

	// sprite
	input  wire [15:0]        sp_addr,
	input  wire               sp_valid,
	output logic [DATA_W-1:0] sp_data,
	output logic              sp_ready,

	// background
	input  wire [15:0]        bg_addr,
	input  wire               bg_valid,
	output logic [DATA_W-1:0] bg_data,
	output logic              bg_ready,

	// audio
	input  wire [15:0]        au_addr,
	input  wire               au_valid,
	output logic [DATA_W-1:0] au_data,
	output logic              au_ready,

	// cpu, the only writer
	input  wire [15:0]        cpu_addr,
	input  wire               cpu_valid,
	input  wire [DATA_W-1:0]  cpu_wdata,
	input  wire               cpu_wr,
	output logic [DATA_W-1:0] cpu_data,
	output logic              cpu_ready
);

	grant_t            grants     [VMEM_N_BANKS];
	logic [DATA_W-1:0] bank_rdata [VMEM_N_BANKS];

	if (DATA_W != VMEM_DATA_W || BANK_ADDR_W != VMEM_BANK_ADDR_W) begin : g_bad_cfg
		$error("vmem_top widths differ from vmem_pkg");
	end

	// one arbiter/ram pair per bank, all see every client
	for (genvar b = 0; b < VMEM_N_BANKS; b++) begin : g_bank
		bank_port_if #(
			.DATA_W      (DATA_W),
			.BANK_ADDR_W (BANK_ADDR_W)
		) port ();

		bank_arbiter #(
			.BANK_ID (b)
		) i_arb (
			.CLK       (CLK),
			.RSTb      (RSTb),
			.sp_addr   (sp_addr),
			.sp_valid  (sp_valid),
			.bg_addr   (bg_addr),
			.bg_valid  (bg_valid),
			.au_addr   (au_addr),
			.au_valid  (au_valid),
			.cpu_addr  (cpu_addr),
			.cpu_valid (cpu_valid),
			.cpu_wdata (cpu_wdata),
			.cpu_wr    (cpu_wr),
			.mem       (port.arb),
			.grant     (grants[b])
		);

		bank_ram #(
			.DATA_W      (DATA_W),
			.BANK_ADDR_W (BANK_ADDR_W)
		) i_ram (
			.CLK (CLK),
			.mem (port.ram)
		);

		assign bank_rdata[b] = port.rdata;
	end

	read_return i_ret (
		.CLK       (CLK),
		.RSTb      (RSTb),
		.grants    (grants),
		.rdata     (bank_rdata),
		.sp_data   (sp_data),
		.bg_data   (bg_data),
		.au_data   (au_data),
		.cpu_data  (cpu_data),
		.sp_ready  (sp_ready),
		.bg_ready  (bg_ready),
		.au_ready  (au_ready),
		.cpu_ready (cpu_ready)
	);

endmodule

`default_nettype wire

// ==== verif/tb_vmem.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_vmem
	import vmem_pkg::*;
;

	typedef struct {
		logic [3:0]  op;
		logic [3:0]  cla;
		logic [15:0] addra;
		logic [15:0] da;
		logic [3:0]  clb;
		logic [15:0] addrb;
		logic [15:0] db;
	} test_t;

	logic        CLK;
	logic        RSTb;
	logic [15:0] c_addr [4];   // indexed by client_e
	logic [3:0]  c_valid;
	logic [15:0] cpu_wdata;
	logic        cpu_wr;
	wire  [3:0]  c_ready;
	wire  [15:0] sp_data, bg_data, au_data, cpu_data;

	test_t       tests [$];
	logic [15:0] model [logic [15:0]];   // expected memory, cpu writes only
	integer      seed;
	logic        loaded;

	vmem_top #(
		.DATA_W      (16),
		.BANK_ADDR_W (14)
	) i_dut (
		.CLK       (CLK),
		.RSTb      (RSTb),
		.sp_addr   (c_addr[0]),
		.sp_valid  (c_valid[0]),
		.sp_data   (sp_data),
		.sp_ready  (c_ready[0]),
		.bg_addr   (c_addr[1]),
		.bg_valid  (c_valid[1]),
		.bg_data   (bg_data),
		.bg_ready  (c_ready[1]),
		.au_addr   (c_addr[2]),
		.au_valid  (c_valid[2]),
		.au_data   (au_data),
		.au_ready  (c_ready[2]),
		.cpu_addr  (c_addr[3]),
		.cpu_valid (c_valid[3]),
		.cpu_wdata (cpu_wdata),
		.cpu_wr    (cpu_wr),
		.cpu_data  (cpu_data),
		.cpu_ready (c_ready[3])
	);

	always #10 CLK = ~CLK;

	task automatic stop_on_error(input string msg);
		$display("ERR %0t: %s", $time, msg);
		$display("TESTBENCH FAILED");
		$fatal(1, "stopped at first error");
	endtask

	task automatic stop_plain(input string msg);
		$display("%s", msg);
		$display("TESTBENCH FAILED");
		$fatal(1, "stopped at first error");
	endtask

	function automatic logic [15:0] data_of(input int c);
		case (c)
			0:       return sp_data;
			1:       return bg_data;
			2:       return au_data;
			default: return cpu_data;
		endcase
	endfunction

	task automatic load_tests();
		int    fd;
		int    n;
		string line;
		test_t t;
		fd = $fopen("verif/vmem_tests.txt", "r");
		assert (fd != 0) else stop_plain("could not open verif/vmem_tests.txt");
		while (!$feof(fd)) begin
			line = "";
			void'($fgets(line, fd));
			if (line.len() < 2 || line[0] == "#")
				continue;   // blank or comment
			n = $sscanf(line, "%h %h %h %h %h %h %h",
				t.op, t.cla, t.addra, t.da, t.clb, t.addrb, t.db);
			assert (n == 7) else stop_plain($sformatf("malformed test line: %s", line));
			tests.push_back(t);
		end
		$fclose(fd);
	endtask

	// data check against the model, file value must agree with it
	task automatic expect_word(input int c, input logic [15:0] a, input logic [15:0] file_exp);
		logic [15:0] got;
		got = data_of(c);
		assert (model.exists(a))
			else stop_plain($sformatf("test file reads %h before writing it", a));
		assert (model[a] == file_exp)
			else stop_plain($sformatf("test file expects %h at %h, model has %h",
				file_exp, a, model[a]));
		assert (got == model[a])
			else stop_on_error($sformatf("client %0d addr %h data %h expected %h",
				c, a, got, model[a]));
	endtask

	task automatic raise_request(input int c, input logic [15:0] a);
		c_addr[c]  <= a;
		c_valid[c] <= 1'b1;
	endtask

	task automatic wait_ready(input int c, output int cycles);
		cycles = 0;
		do begin
			@(negedge CLK);
			cycles++;
		end while (!c_ready[c]);
	endtask

	task automatic wait_idle();
		do
			@(negedge CLK);
		while (c_ready != 4'b0);
	endtask

	task automatic check_quiet();
		@(negedge CLK);
		assert (c_ready == 4'b0)
			else stop_on_error($sformatf("readies %b with no request", c_ready));
	endtask

	task automatic write_word(input int c, input logic [15:0] a, input logic [15:0] d);
		int cycles;
		assert (c == CL_CPU) else stop_plain("test file has a write from a client other than the CPU");
		@(posedge CLK);
		raise_request(c, a);
		cpu_wdata <= d;
		cpu_wr    <= 1'b1;
		wait_ready(c, cycles);
		assert (cycles == 2)
			else stop_on_error($sformatf("cpu write ready after %0d cycles on a free bank",
				cycles));
		@(posedge CLK);
		c_valid[c] <= 1'b0;
		cpu_wr     <= 1'b0;
		model[a] = d;
		wait_idle();
	endtask

	task automatic read_word(input int c, input logic [15:0] a, input logic [15:0] e);
		int cycles;
		@(posedge CLK);
		raise_request(c, a);
		wait_ready(c, cycles);
		assert (cycles == 2)
			else stop_on_error($sformatf("client %0d ready after %0d cycles on a free bank",
				c, cycles));
		expect_word(c, a, e);
		@(posedge CLK);
		c_valid[c] <= 1'b0;
		wait_idle();
	endtask

	task automatic request_pair(input test_t t);
		int          hc, lc;
		logic [15:0] ha, hd, la, ld;
		hc = (t.cla < t.clb) ? t.cla : t.clb;   // lower index wins
		lc = (t.cla < t.clb) ? t.clb : t.cla;
		ha = (t.cla < t.clb) ? t.addra : t.addrb;
		hd = (t.cla < t.clb) ? t.da : t.db;
		la = (t.cla < t.clb) ? t.addrb : t.addra;
		ld = (t.cla < t.clb) ? t.db : t.da;
		@(posedge CLK);
		raise_request(hc, ha);
		raise_request(lc, la);
		repeat (2) @(negedge CLK);   // request cycle, then the granted cycle
		if (ha[15:14] != la[15:14]) begin
			assert (c_ready[hc] && c_ready[lc])
				else stop_on_error($sformatf("split banks, readies %b one cycle on", c_ready));
			expect_word(hc, ha, hd);
			expect_word(lc, la, ld);
			@(posedge CLK);
			c_valid[hc] <= 1'b0;
			c_valid[lc] <= 1'b0;
		end else begin
			assert (c_ready[hc] && !c_ready[lc])
				else stop_on_error($sformatf("shared bank, readies %b, client %0d should win",
					c_ready, hc));
			expect_word(hc, ha, hd);
			@(posedge CLK);
			c_valid[hc] <= 1'b0;
			do begin
				@(negedge CLK);
				assert (!(c_ready[hc] && c_ready[lc]))
					else stop_on_error("both clients ready on one bank");
			end while (!c_ready[lc]);
			expect_word(lc, la, ld);
			@(posedge CLK);
			c_valid[lc] <= 1'b0;
		end
		wait_idle();
	endtask

	task automatic hop_address(input test_t t);
		int cycles;
		assert (t.addra[15:14] == t.addrb[15:14])
			else stop_plain("test file hops between banks");
		@(posedge CLK);
		raise_request(t.cla, t.addra);
		wait_ready(t.cla, cycles);
		assert (cycles == 2)
			else stop_on_error($sformatf("client %0d ready after %0d cycles on a free bank",
				t.cla, cycles));
		expect_word(t.cla, t.addra, t.da);
		@(posedge CLK);
		c_addr[t.cla] <= t.addrb;
		@(posedge CLK);   // ram latches the new offset here
		@(negedge CLK);
		assert (c_ready[t.cla]) else stop_on_error("grant lost while valid held");
		expect_word(t.cla, t.addrb, t.db);
		@(posedge CLK);
		c_valid[t.cla] <= 1'b0;
		wait_idle();
	endtask

	task automatic run_line(input test_t t);
		case (t.op)
			4'd0: check_quiet();
			4'd1: write_word(t.cla, t.addra, t.da);
			4'd2: read_word(t.cla, t.addra, t.da);
			4'd3: request_pair(t);
			4'd4: hop_address(t);
			default: stop_plain($sformatf("unknown operation %0d in test file", t.op));
		endcase
	endtask

	initial begin : watchdog
		wait (loaded === 1'b1);
		repeat (tests.size() * 50 + 20) @(posedge CLK);
		$display("timeout: tests did not finish within %0d cycles", tests.size() * 50 + 20);
		$display("TESTBENCH FAILED");
		$fatal(1, "watchdog expired");
	end

	initial begin : main
		int gap;
		CLK       = 1'b0;
		RSTb      = 1'b0;
		c_valid   = 4'b0;
		cpu_wdata = 16'h0;
		cpu_wr    = 1'b0;
		loaded    = 1'b0;
		seed      = 32'haadf_14c8;
		for (int i = 0; i < 4; i++) begin
			c_addr[i] = 16'h0;
		end
		load_tests();
		loaded = 1'b1;
		repeat (10) @(posedge CLK);
		RSTb <= 1'b1;
		foreach (tests[i]) begin
			run_line(tests[i]);
			gap = $random(seed);
			repeat (gap & 3) @(posedge CLK);   // 0 to 3 idle cycles
		end
		$display("TESTBENCH PASSED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== verif/vmem_tests.txt ====
# op: 0 quiet check, 1 cpu write, 2 read, 3 two-client pair, 4 address hop while granted
# op client_a addr_a data_a client_b addr_b data_b (hex; clients 0 sp, 1 bg, 2 au, 3 cpu)
0 0 0000 0000 0 0000 0000
1 3 0010 1234 0 0000 0000
1 3 4020 5678 0 0000 0000
1 3 8030 9abc 0 0000 0000
1 3 c040 def0 0 0000 0000
2 3 0010 1234 0 0000 0000
2 3 4020 5678 0 0000 0000
2 3 8030 9abc 0 0000 0000
2 3 c040 def0 0 0000 0000
# fill more words for the display and sound clients
1 3 0011 a5a5 0 0000 0000
1 3 0012 0f0f 0 0000 0000
1 3 4021 3c3c 0 0000 0000
1 3 4022 1111 0 0000 0000
1 3 8031 2222 0 0000 0000
1 3 8032 7e57 0 0000 0000
1 3 c041 beef 0 0000 0000
1 3 c042 cafe 0 0000 0000
1 3 3fff 0bad 0 0000 0000
2 0 0011 a5a5 0 0000 0000
2 1 4021 3c3c 0 0000 0000
2 2 8031 2222 0 0000 0000
2 0 c041 beef 0 0000 0000
2 1 3fff 0bad 0 0000 0000
2 2 c042 cafe 0 0000 0000
# same bank, higher priority served first
3 0 0010 1234 1 0011 a5a5
3 2 4020 5678 0 4022 1111
3 1 8031 2222 3 8032 7e57
3 3 c040 def0 2 c042 cafe
# different banks, served together
3 0 0012 0f0f 1 4021 3c3c
3 2 8030 9abc 3 c041 beef
3 1 3fff 0bad 2 4022 1111
1 3 0010 4321 0 0000 0000
2 0 0010 4321 0 0000 0000
# hop: client, first addr and data, unused, new addr and data
4 0 0010 4321 0 0012 0f0f
4 2 8030 9abc 0 8032 7e57
4 3 c040 def0 0 c042 cafe
4 1 4020 5678 0 4021 3c3c
0 0 0000 0000 0 0000 0000

// ==== filelist.f ====
source/vmem_pkg.sv
source/bank_port_if.sv
source/bank_arbiter.sv
source/bank_ram.sv
source/read_return.sv
source/vmem_top.sv
verif/tb_vmem.sv
